//--- include/lsu_defines.svh
// word geometry and access type codes of the load/store unit
`ifndef LSU_DEFINES_SVH
`define LSU_DEFINES_SVH

// word geometry, alignment tables assume a 32-bit word
`define LSU_DATA_W 32 // data and address width
`define LSU_BYTES  4  // bytes per data word
`define LSU_OFFS_W 2  // byte offset inside a word

// access type codes as driven by the execute stage
`define LSU_TYPE_WORD 2'b00
`define LSU_TYPE_HALF 2'b01
`define LSU_TYPE_BYTE 2'b10

// code 2'b11 decodes as a byte access as well,
// so every type decoder sends it down the byte path

`endif

//--- hw/lsu_pkg.sv
// shared vector types and the transaction FSM state enum of the load/store unit
`include "lsu_defines.svh"

package lsu_pkg;

  //////////////////////////////////////////////////////////////////////
  // vector types
  //////////////////////////////////////////////////////////////////////

  typedef logic [`LSU_DATA_W-1:0] lsu_word_t; // data or address word
  typedef logic [`LSU_BYTES-1:0]  lsu_be_t;   // one enable per byte lane
  typedef logic [`LSU_OFFS_W-1:0] lsu_offs_t; // byte offset in a word
  typedef logic [1:0]             lsu_type_t; // word, half or byte

  //////////////////////////////////////////////////////////////////////
  // transaction FSM
  //////////////////////////////////////////////////////////////////////

  // the MIS states belong to the first part of a split access
  typedef enum logic [2:0] {
    IDLE                      = 3'd0, // no request pending on the bus
    WAIT_GNT_MIS              = 3'd1, // first part waits for its grant
    WAIT_RVALID_MIS           = 3'd2, // first rvalid pending, second req out
    WAIT_GNT                  = 3'd3, // single or second part waits for grant
    WAIT_RVALID_MIS_GNTS_DONE = 3'd4  // both granted, first rvalid pending
  } lsu_fsm_e;

endpackage

//--- hw/lsu_ctrl_fsm.sv
// transaction FSM with split detection, error and last-address registers and status
`timescale 1ns/1ps
`include "lsu_defines.svh"

module lsu_ctrl_fsm (
  input  logic              clk_i,
  input  logic              rst_ni,
  // execute stage
  input  logic              lsu_req_i,
  input  logic              lsu_we_i,
  input  lsu_pkg::lsu_type_t lsu_type_i,
  input  lsu_pkg::lsu_word_t data_addr_i,       // unaligned address from the ALU
  // bus handshake
  input  logic              data_gnt_i,
  input  logic              data_rvalid_i,
  input  logic              data_err_i,
  output logic              data_req_o,
  // towards execute stage and datapath
  output logic              addr_incr_req_o,    // ask for last address plus 4
  output logic              ctrl_update_o,      // latch access attributes
  output logic              rdata_update_o,     // latch first-part read word
  output logic              second_part_o,      // second part of a split in flight
  output lsu_pkg::lsu_word_t addr_last_o,
  // status
  output logic              lsu_req_done_o,
  output logic              lsu_resp_valid_o,
  output logic              lsu_rdata_valid_o,
  output logic              load_err_o,
  output logic              store_err_o,
  output logic              busy_o
);

  import lsu_pkg::*;

  lsu_fsm_e  fsm_cs, fsm_ns;
  lsu_offs_t data_offs;
  lsu_word_t addr_last_q;
  logic      addr_update;
  logic      split_access;
  logic      second_part_q, second_part_d;
  logic      lsu_err_q, lsu_err_d;     // error seen on the first part
  logic      data_we_q;                // store flag of the running access
  logic      any_err;
  logic [1:0] outstanding_q;           // granted but not yet answered

  assign data_offs = data_addr_i[`LSU_OFFS_W-1:0];

  // word at non-zero offset or half word crossing into the next word
  assign split_access =
      ((lsu_type_i == `LSU_TYPE_WORD) && (data_offs != 2'b00)) ||
      ((lsu_type_i == `LSU_TYPE_HALF) && (data_offs == 2'b11));

  //////////////////////////////////////////////////////////////////////
  // next state
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    fsm_ns          = fsm_cs;
    data_req_o      = 1'b0;
    addr_incr_req_o = 1'b0;
    addr_update     = 1'b0;
    ctrl_update_o   = 1'b0;
    rdata_update_o  = 1'b0;
    second_part_d   = second_part_q;
    lsu_err_d       = lsu_err_q;

    unique case (fsm_cs)
      IDLE: begin
        if (lsu_req_i) begin
          data_req_o = 1'b1;
          lsu_err_d  = 1'b0;                 // fresh access, no error yet
          if (data_gnt_i) begin
            ctrl_update_o = 1'b1;
            addr_update   = 1'b1;
            second_part_d = split_access;
            fsm_ns        = split_access ? WAIT_RVALID_MIS : IDLE;
          end else begin
            fsm_ns        = split_access ? WAIT_GNT_MIS : WAIT_GNT;
          end
        end
      end

      WAIT_GNT_MIS: begin
        data_req_o = 1'b1;                   // hold first part until granted
        if (data_gnt_i) begin
          ctrl_update_o = 1'b1;
          addr_update   = 1'b1;
          second_part_d = 1'b1;
          fsm_ns        = WAIT_RVALID_MIS;
        end
      end

      WAIT_RVALID_MIS: begin
        data_req_o      = 1'b1;              // second part already on the bus
        addr_incr_req_o = 1'b1;
        if (data_rvalid_i) begin
          lsu_err_d      = data_err_i;       // remember first-part outcome
          rdata_update_o = ~data_we_q;
          // keep the failing address for the trap handler
          addr_update    = data_gnt_i & ~data_err_i;
          second_part_d  = ~data_gnt_i;
          fsm_ns         = data_gnt_i ? IDLE : WAIT_GNT;
        end else if (data_gnt_i) begin
          second_part_d = 1'b0;
          fsm_ns        = WAIT_RVALID_MIS_GNTS_DONE;
        end
      end

      WAIT_GNT: begin
        data_req_o      = 1'b1;
        addr_incr_req_o = second_part_q;     // only for the second part
        if (data_gnt_i) begin
          ctrl_update_o = 1'b1;
          addr_update   = ~lsu_err_q;
          second_part_d = 1'b0;
          fsm_ns        = IDLE;
        end
      end

      WAIT_RVALID_MIS_GNTS_DONE: begin
        addr_incr_req_o = 1'b1;              // second address stays visible
        if (data_rvalid_i) begin
          lsu_err_d      = data_err_i;
          addr_update    = ~data_err_i;
          rdata_update_o = ~data_we_q;
          fsm_ns         = IDLE;             // only the last rvalid remains
        end
      end

      default: fsm_ns = IDLE;
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // registers
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      fsm_cs        <= IDLE;
      second_part_q <= 1'b0;
      lsu_err_q     <= 1'b0;
      data_we_q     <= 1'b0;
      addr_last_q   <= '0;
      outstanding_q <= 2'd0;
    end else begin
      fsm_cs        <= fsm_ns;
      second_part_q <= second_part_d;
      lsu_err_q     <= lsu_err_d;
      if (ctrl_update_o) data_we_q <= lsu_we_i;
      if (addr_update) addr_last_q <= data_addr_i;
      // grant adds a response, rvalid retires one
      if ((data_req_o && data_gnt_i) && !data_rvalid_i) begin
        outstanding_q <= outstanding_q + 2'd1;
      end else if (!(data_req_o && data_gnt_i) && data_rvalid_i) begin
        outstanding_q <= outstanding_q - 2'd1;
      end
    end
  end

  // status outputs
  assign any_err           = lsu_err_q | data_err_i;   // either part failed
  assign lsu_req_done_o    = (lsu_req_i | (fsm_cs != IDLE)) & (fsm_ns == IDLE);
  assign lsu_resp_valid_o  = data_rvalid_i & (fsm_cs == IDLE); // final rvalid only
  assign lsu_rdata_valid_o = lsu_resp_valid_o & ~any_err & ~data_we_q;
  assign load_err_o        = lsu_resp_valid_o & any_err & ~data_we_q;
  assign store_err_o       = lsu_resp_valid_o & any_err &  data_we_q;
  assign second_part_o     = second_part_q;
  assign addr_last_o       = addr_last_q;
  assign busy_o            = (fsm_cs != IDLE);

  // a response in IDLE must belong to a grant given earlier
  a_rvalid_outstanding : assert property (@(posedge clk_i) disable iff (!rst_ni)
    (data_rvalid_i && (fsm_cs == IDLE)) |-> (outstanding_q != 2'd0))
    else $error("rvalid in IDLE with no outstanding request");

  a_state_legal : assert property (@(posedge clk_i) disable iff (!rst_ni)
    fsm_cs inside {IDLE, WAIT_GNT_MIS, WAIT_RVALID_MIS, WAIT_GNT,
                   WAIT_RVALID_MIS_GNTS_DONE})
    else $error("illegal FSM state %0d", fsm_cs);

endmodule

//--- hw/lsu_wdata_align.sv
// byte enable generation and store data rotation for the data bus
`timescale 1ns/1ps
`include "lsu_defines.svh"

module lsu_wdata_align (
  input  lsu_pkg::lsu_type_t lsu_type_i,
  input  lsu_pkg::lsu_offs_t data_offs_i,   // low address bits of the access
  input  logic               second_part_i,  // upper word of a split access
  input  lsu_pkg::lsu_word_t lsu_wdata_i,
  output lsu_pkg::lsu_be_t   data_be_o,
  output lsu_pkg::lsu_word_t data_wdata_o
);

  import lsu_pkg::*;

  lsu_be_t be_first;   // lanes from the offset upwards
  lsu_be_t be_second;  // lanes spilling into the next word

  //////////////////////////////////////////////////////////////////////
  // byte enables
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    unique case (lsu_type_i)
      `LSU_TYPE_WORD: begin
        be_first = 4'b1111 << data_offs_i;     // 1111 1110 1100 1000
        unique case (data_offs_i)
          2'b01:   be_second = 4'b0001;
          2'b10:   be_second = 4'b0011;
          2'b11:   be_second = 4'b0111;
          default: be_second = 4'b1111;         // aligned word never splits
        endcase
      end
      `LSU_TYPE_HALF: begin
        be_first  = 4'b0011 << data_offs_i;    // offset 3 keeps only lane 3
        be_second = 4'b0001;                   // top byte lands in lane 0
      end
      default: begin                           // byte, codes 2 and 3
        be_first  = 4'b0001 << data_offs_i;
        be_second = 4'b0001 << data_offs_i;    // bytes never split
      end
    endcase
  end

  assign data_be_o = second_part_i ? be_second : be_first;

  // store data rotated left by the offset in bytes, same for both parts
  always_comb begin
    unique case (data_offs_i)
      2'b01:   data_wdata_o = {lsu_wdata_i[23:0], lsu_wdata_i[31:24]};
      2'b10:   data_wdata_o = {lsu_wdata_i[15:0], lsu_wdata_i[31:16]};
      2'b11:   data_wdata_o = {lsu_wdata_i[7:0],  lsu_wdata_i[31:8]};
      default: data_wdata_o = lsu_wdata_i;
    endcase
  end

  // the second part always starts at lane 0 of the next word
  always_comb begin
    a_second_lane0 : assert final (!second_part_i || data_be_o[0])
      else $error("second part misses lane 0, type %0d offs %0d", lsu_type_i, data_offs_i);
  end

endmodule

//--- hw/lsu_rdata_align.sv
// first-part read data and access attribute registers, load realignment and extension
`timescale 1ns/1ps
`include "lsu_defines.svh"

module lsu_rdata_align (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               ctrl_update_i,   // access granted, latch attributes
  input  logic               rdata_update_i,  // first-part rvalid of a split load
  input  lsu_pkg::lsu_offs_t data_offs_i,
  input  lsu_pkg::lsu_type_t lsu_type_i,
  input  logic               lsu_sign_ext_i,
  input  lsu_pkg::lsu_word_t data_rdata_i,
  output lsu_pkg::lsu_word_t lsu_rdata_o
);

  import lsu_pkg::*;

  logic [`LSU_DATA_W-1:8] rdata_q;  // bytes 1..3 of the first word
  lsu_offs_t offs_q;
  lsu_type_t type_q;
  logic      sign_ext_q;

  lsu_word_t   rdata_w;   // realigned word
  logic [15:0] rdata_h;   // selected half word
  logic [7:0]  rdata_b;   // selected byte

  //////////////////////////////////////////////////////////////////////
  // registers
  //////////////////////////////////////////////////////////////////////

  // payload only, the lower byte is never needed for recombination
  always_ff @(posedge clk_i) begin
    if (rdata_update_i) begin
      rdata_q <= data_rdata_i[`LSU_DATA_W-1:8];
    end
  end

  // access attributes steer the output muxes
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      offs_q     <= '0;
      type_q     <= `LSU_TYPE_WORD;
      sign_ext_q <= 1'b0;
    end else if (ctrl_update_i) begin
      offs_q     <= data_offs_i;
      type_q     <= lsu_type_i;
      sign_ext_q <= lsu_sign_ext_i;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // realignment
  //////////////////////////////////////////////////////////////////////

  // low part comes from the first word, high part from the current one
  always_comb begin
    unique case (offs_q)
      2'b01:   rdata_w = {data_rdata_i[7:0],  rdata_q[31:8]};
      2'b10:   rdata_w = {data_rdata_i[15:0], rdata_q[31:16]};
      2'b11:   rdata_w = {data_rdata_i[23:0], rdata_q[31:24]};
      default: rdata_w = data_rdata_i;             // aligned word
    endcase
  end

  always_comb begin
    unique case (offs_q)
      2'b01:   rdata_h = data_rdata_i[23:8];
      2'b10:   rdata_h = data_rdata_i[31:16];
      2'b11:   rdata_h = {data_rdata_i[7:0], rdata_q[31:24]}; // crosses words
      default: rdata_h = data_rdata_i[15:0];
    endcase
  end

  // a byte sits in one lane, picked by the offset
  always_comb begin
    unique case (offs_q)
      2'b01:   rdata_b = data_rdata_i[15:8];
      2'b10:   rdata_b = data_rdata_i[23:16];
      2'b11:   rdata_b = data_rdata_i[31:24];
      default: rdata_b = data_rdata_i[7:0];
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // extension and type select
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    unique case (type_q)
      `LSU_TYPE_WORD: lsu_rdata_o = rdata_w;
      `LSU_TYPE_HALF: lsu_rdata_o = {{16{sign_ext_q & rdata_h[15]}}, rdata_h};
      default:        lsu_rdata_o = {{24{sign_ext_q & rdata_b[7]}}, rdata_b}; // byte
    endcase
  end

endmodule

//--- hw/lsu_top.sv
// load/store unit top level joining control FSM, store alignment and load alignment
`timescale 1ns/1ps
`include "lsu_defines.svh"

module lsu_top (
  input  logic               clk_i,
  input  logic               rst_ni,
  // data bus
  output logic               data_req_o,
  input  logic               data_gnt_i,
  input  logic               data_rvalid_i,
  input  logic               data_err_i,
  output lsu_pkg::lsu_word_t data_addr_o,     // always word aligned
  output logic               data_we_o,
  output lsu_pkg::lsu_be_t   data_be_o,
  output lsu_pkg::lsu_word_t data_wdata_o,
  input  lsu_pkg::lsu_word_t data_rdata_i,
  // execute stage
  input  logic               lsu_req_i,
  input  logic               lsu_we_i,
  input  lsu_pkg::lsu_type_t lsu_type_i,
  input  logic               lsu_sign_ext_i,
  input  lsu_pkg::lsu_word_t lsu_wdata_i,
  input  lsu_pkg::lsu_word_t adder_result_ex_i, // address from the ALU
  output lsu_pkg::lsu_word_t lsu_rdata_o,
  output logic               lsu_rdata_valid_o,
  output logic               addr_incr_req_o,
  output lsu_pkg::lsu_word_t addr_last_o,       // for mtval and split address
  output logic               lsu_req_done_o,
  output logic               lsu_resp_valid_o,
  // exceptions and status
  output logic               load_err_o,
  output logic               store_err_o,
  output logic               busy_o
);

  import lsu_pkg::*;

  lsu_offs_t data_offs;
  logic      ctrl_update;
  logic      rdata_update;
  logic      second_part;

  assign data_offs   = adder_result_ex_i[`LSU_OFFS_W-1:0];
  // bus only sees word addresses, the offset lives in the byte enables
  assign data_addr_o = {adder_result_ex_i[`LSU_DATA_W-1:`LSU_OFFS_W], {`LSU_OFFS_W{1'b0}}};
  assign data_we_o   = lsu_we_i;

  lsu_ctrl_fsm u_ctrl_fsm (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .lsu_req_i         (lsu_req_i),
    .lsu_we_i          (lsu_we_i),
    .lsu_type_i        (lsu_type_i),
    .data_addr_i       (adder_result_ex_i),
    .data_gnt_i        (data_gnt_i),
    .data_rvalid_i     (data_rvalid_i),
    .data_err_i        (data_err_i),
    .data_req_o        (data_req_o),
    .addr_incr_req_o   (addr_incr_req_o),
    .ctrl_update_o     (ctrl_update),
    .rdata_update_o    (rdata_update),
    .second_part_o     (second_part),
    .addr_last_o       (addr_last_o),
    .lsu_req_done_o    (lsu_req_done_o),
    .lsu_resp_valid_o  (lsu_resp_valid_o),
    .lsu_rdata_valid_o (lsu_rdata_valid_o),
    .load_err_o        (load_err_o),
    .store_err_o       (store_err_o),
    .busy_o            (busy_o)
  );

  lsu_wdata_align u_wdata_align (
    .lsu_type_i    (lsu_type_i),
    .data_offs_i   (data_offs),
    .second_part_i (second_part),
    .lsu_wdata_i   (lsu_wdata_i),
    .data_be_o     (data_be_o),
    .data_wdata_o  (data_wdata_o)
  );

  lsu_rdata_align u_rdata_align (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .ctrl_update_i  (ctrl_update),
    .rdata_update_i (rdata_update),
    .data_offs_i    (data_offs),
    .lsu_type_i     (lsu_type_i),
    .lsu_sign_ext_i (lsu_sign_ext_i),
    .data_rdata_i   (data_rdata_i),
    .lsu_rdata_o    (lsu_rdata_o)
  );

endmodule

//--- tb/tb_lsu.sv
// testbench for the load/store unit with pattern file stimulus, bus responder and timeout
`timescale 1ns/1ps
`include "lsu_defines.svh"

module tb_lsu;

  localparam int MAX_PAT     = 64;
  localparam int CYC_PER_PAT = 40; // cycle budget of one access

  logic        clk_i, rst_ni;
  logic        data_req_o, data_gnt_i, data_rvalid_i, data_err_i, data_we_o;
  logic [31:0] data_addr_o, data_wdata_o, data_rdata_i;
  logic [3:0]  data_be_o;
  logic        lsu_req_i, lsu_we_i, lsu_sign_ext_i;
  logic [1:0]  lsu_type_i;
  logic [31:0] lsu_wdata_i, adder_result_ex_i, lsu_rdata_o, addr_last_o;
  logic        lsu_rdata_valid_o, addr_incr_req_o, lsu_req_done_o, lsu_resp_valid_o;
  logic        load_err_o, store_err_o, busy_o;

  // one entry per pattern line
  logic        p_we [MAX_PAT];
  logic [1:0]  p_type [MAX_PAT];
  logic        p_sext [MAX_PAT];
  logic [31:0] p_addr [MAX_PAT];
  logic [31:0] p_wdata [MAX_PAT];
  logic [31:0] p_mem1 [MAX_PAT];   // word returned for the first part
  logic [31:0] p_mem2 [MAX_PAT];   // word returned for the second part
  logic        p_err1 [MAX_PAT];
  logic        p_err2 [MAX_PAT];
  logic [31:0] p_rdata [MAX_PAT];
  logic [3:0]  p_be1 [MAX_PAT];
  logic [31:0] p_wd1 [MAX_PAT];
  logic [3:0]  p_be2 [MAX_PAT];
  logic [31:0] p_wd2 [MAX_PAT];
  logic        p_lerr [MAX_PAT];
  logic        p_serr [MAX_PAT];

  int          n_pat, cur, nparts, grants, done_cnt, gnt_wait;
  int          cycle, limit, val_errs, proto_errs;
  int unsigned seed, seed_out;
  bit          resp_seen, hold_valid;
  logic [31:0] hold_addr, hold_wdata, exp_last;
  logic [3:0]  hold_be;
  int          rsp_ready[$];       // cycle in which each response may return
  int          rsp_part[$];        // part index of each outstanding response

  lsu_top u_dut (.*);

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
    $display("ERR %s got %h exp %h (pattern %0d)", name, got, exp, cur);
    val_errs++;
  endtask

  task automatic report_failure(input string msg);
    $display("%s (pattern %0d)", msg, cur);
    proto_errs++;
  endtask

  // word at a non-zero offset or half word at offset 3 needs two bus words
  function automatic bit is_split(input logic [1:0] t, input logic [1:0] offs);
    return ((t == `LSU_TYPE_WORD) && (offs != 2'd0)) ||
           ((t == `LSU_TYPE_HALF) && (offs == 2'd3));
  endfunction

  task automatic load_patterns();
    int               fd;
    int               cnt;
    logic [8*256-1:0] line;
    n_pat = 0;
    fd = $fopen("tb/lsu_patterns.txt", "r");
    if (fd == 0) begin
      report_failure("cannot open tb/lsu_patterns.txt");
    end else begin
      while (!$feof(fd) && (n_pat < MAX_PAT)) begin
        line = '0;
        if ($fgets(line, fd) != 0) begin
          cnt = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                        p_we[n_pat], p_type[n_pat], p_sext[n_pat], p_addr[n_pat],
                        p_wdata[n_pat], p_mem1[n_pat], p_mem2[n_pat], p_err1[n_pat],
                        p_err2[n_pat], p_rdata[n_pat], p_be1[n_pat], p_wd1[n_pat],
                        p_be2[n_pat], p_wd2[n_pat], p_lerr[n_pat], p_serr[n_pat]);
          if (cnt == 16) n_pat++;  // comment lines scan to nothing
        end
      end
      $fclose(fd);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // falling edge: execute stage and bus responder drive
  //////////////////////////////////////////////////////////////////////

  task automatic drive_cycle();
    lsu_req_i         = (done_cnt == 0);            // hold until request done
    lsu_we_i          = p_we[cur];
    lsu_type_i        = p_type[cur];
    lsu_sign_ext_i    = p_sext[cur];
    lsu_wdata_i       = p_wdata[cur];
    adder_result_ex_i = addr_incr_req_o ? addr_last_o + 32'd4 : p_addr[cur];
    data_gnt_i        = (gnt_wait == 0);
    if ((rsp_ready.size() > 0) && (rsp_ready[0] <= cycle)) begin
      data_rvalid_i = 1'b1;
      data_rdata_i  = (rsp_part[0] != 0) ? p_mem2[cur] : p_mem1[cur];
      data_err_i    = (rsp_part[0] != 0) ? p_err2[cur] : p_err1[cur];
    end else begin
      data_rvalid_i = 1'b0;
      data_rdata_i  = $urandom;                      // garbage outside rvalid
      data_err_i    = 1'b0;
    end
  endtask

  // sampled mid cycle, before the rising edge
  task automatic sample_cycle();
    logic [31:0] exp_addr;
    int          part;
    exp_addr = {p_addr[cur][31:2], 2'b00} + 32'(4 * grants);
    if (hold_valid) begin
      if (!data_req_o || (data_addr_o !== hold_addr) || (data_be_o !== hold_be) ||
          (data_wdata_o !== hold_wdata))
        report_failure("request dropped or changed before its grant");
      if (busy_o !== 1'b1) report_mismatch("busy_o", busy_o, 32'h1);
    end
    if (data_req_o && data_gnt_i) begin
      if (grants >= nparts) begin
        report_failure("more bus grants than parts of the access");
      end else begin
        if (data_addr_o !== exp_addr) report_mismatch("data_addr_o", data_addr_o, exp_addr);
        if (data_we_o !== p_we[cur]) report_mismatch("data_we_o", data_we_o, p_we[cur]);
        if (data_be_o !== ((grants == 0) ? p_be1[cur] : p_be2[cur]))
          report_mismatch("data_be_o", data_be_o, (grants == 0) ? p_be1[cur] : p_be2[cur]);
        if (data_wdata_o !== ((grants == 0) ? p_wd1[cur] : p_wd2[cur]))
          report_mismatch("data_wdata_o", data_wdata_o,
                          (grants == 0) ? p_wd1[cur] : p_wd2[cur]);
        // final grant with no older response left ends the request
        if ((grants == nparts - 1) && (rsp_ready.size() - int'(data_rvalid_i) == 0) &&
            !lsu_req_done_o)
          report_failure("lsu_req_done_o low on the final grant");
      end
      rsp_ready.push_back(cycle + 1 + int'($urandom % 4));
      rsp_part.push_back(grants);
      grants++;
      gnt_wait = $urandom % 4;
    end else if (data_req_o && (gnt_wait > 0)) begin
      gnt_wait--;
    end
    hold_valid = data_req_o && !data_gnt_i;
    hold_addr  = data_addr_o;
    hold_be    = data_be_o;
    hold_wdata = data_wdata_o;
    if (lsu_req_done_o) done_cnt++;
    if (data_rvalid_i) begin
      part = rsp_part.pop_front();
      void'(rsp_ready.pop_front());
      if (part == nparts - 1) begin
        resp_seen = 1'b1;
        if (!lsu_resp_valid_o) report_failure("no lsu_resp_valid_o on the final rvalid");
        if (lsu_rdata_valid_o !== (!p_we[cur] && !p_lerr[cur]))
          report_mismatch("lsu_rdata_valid_o", lsu_rdata_valid_o,
                          !p_we[cur] && !p_lerr[cur]);
        if (load_err_o !== p_lerr[cur]) report_mismatch("load_err_o", load_err_o, p_lerr[cur]);
        if (store_err_o !== p_serr[cur])
          report_mismatch("store_err_o", store_err_o, p_serr[cur]);
        if (!p_we[cur] && !p_lerr[cur] && (lsu_rdata_o !== p_rdata[cur]))
          report_mismatch("lsu_rdata_o", lsu_rdata_o, p_rdata[cur]);
      end else if (lsu_resp_valid_o) begin
        report_failure("response given for the first part of a split access");
      end
    end else if (lsu_resp_valid_o) begin
      report_failure("lsu_resp_valid_o high without rvalid");
    end
  endtask

  task automatic run_access();
    nparts     = is_split(p_type[cur], p_addr[cur][1:0]) ? 2 : 1;
    grants     = 0;
    done_cnt   = 0;
    resp_seen  = 1'b0;
    hold_valid = 1'b0;
    gnt_wait   = $urandom % 4;
    while (!resp_seen) begin
      @(negedge clk_i);
      drive_cycle();
      #2;
      sample_cycle();
    end
    @(negedge clk_i);
    lsu_req_i     = 1'b0;
    data_gnt_i    = 1'b0;
    data_rvalid_i = 1'b0;
    data_err_i    = 1'b0;
    #2;
    // first failing address is kept, otherwise the last word address
    exp_last = (nparts == 2 && !p_err1[cur]) ? p_addr[cur] + 32'd4 : p_addr[cur];
    if (addr_last_o !== exp_last) report_mismatch("addr_last_o", addr_last_o, exp_last);
    if (done_cnt != 1) report_failure("lsu_req_done_o did not pulse exactly once");
    if (busy_o !== 1'b0) report_mismatch("busy_o", busy_o, 32'h0);
    if (rsp_ready.size() != 0) report_failure("bus responses left over after the access");
  endtask

  // cycle counter and watchdog
  initial begin
    cycle = 0;
    forever begin
      @(posedge clk_i);
      cycle++;
      if ((limit > 0) && (cycle > limit)) begin
        $display("timeout: access %0d got no response within %0d cycles", cur, limit);
        $display("Simulation finished: FAIL");
        $finish;
      end
    end
  end

  initial begin
    seed              = 32'h3466a174;
    seed_out          = $urandom(seed);
    rst_ni            = 1'b0;
    lsu_req_i         = 1'b0;
    lsu_we_i          = 1'b0;
    lsu_type_i        = `LSU_TYPE_WORD;
    lsu_sign_ext_i    = 1'b0;
    lsu_wdata_i       = '0;
    adder_result_ex_i = '0;
    data_gnt_i        = 1'b0;
    data_rvalid_i     = 1'b0;
    data_err_i        = 1'b0;
    data_rdata_i      = '0;
    val_errs          = 0;
    proto_errs        = 0;
    cur               = 0;
    limit             = 0;
    load_patterns();
    limit = CYC_PER_PAT * n_pat + 20;   // reset and settle on top
    repeat (10) @(negedge clk_i);
    rst_ni = 1'b1;
    #2;
    if (data_req_o !== 1'b0) report_mismatch("data_req_o", data_req_o, 32'h0);
    if (addr_incr_req_o !== 1'b0) report_mismatch("addr_incr_req_o", addr_incr_req_o, 32'h0);
    if (lsu_req_done_o !== 1'b0) report_mismatch("lsu_req_done_o", lsu_req_done_o, 32'h0);
    if (busy_o !== 1'b0) report_mismatch("busy_o", busy_o, 32'h0);
    if (load_err_o !== 1'b0) report_mismatch("load_err_o", load_err_o, 32'h0);
    if (store_err_o !== 1'b0) report_mismatch("store_err_o", store_err_o, 32'h0);
    if (n_pat == 0) report_failure("no pattern lines were read");
    for (cur = 0; cur < n_pat; cur++) begin
      run_access();
    end
    $display("errors: %0d value mismatches, %0d protocol failures", val_errs, proto_errs);
    if ((val_errs + proto_errs) == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

//--- list.f
+incdir+include
hw/lsu_pkg.sv
hw/lsu_ctrl_fsm.sv
hw/lsu_wdata_align.sv
hw/lsu_rdata_align.sv
hw/lsu_top.sv
tb/tb_lsu.sv

//--- Bender.yml
package:
  name: lsu

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - hw/lsu_pkg.sv
      - hw/lsu_ctrl_fsm.sv
      - hw/lsu_wdata_align.sv
      - hw/lsu_rdata_align.sv
      - hw/lsu_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - tb/tb_lsu.sv

//--- tb/lsu_patterns.txt
// we type sext addr wdata mem1 mem2 err1 err2 rdata be1 wdata1 be2 wdata2 lerr serr
// all fields hex, second-part columns are zero for single-part accesses
1 0 0 00001000 11223344 00000000 00000000 0 0 00000000 f 11223344 0 00000000 0 0
1 1 0 00001002 11223344 00000000 00000000 0 0 00000000 c 33441122 0 00000000 0 0
1 2 0 00001005 11223344 00000000 00000000 0 0 00000000 2 22334411 0 00000000 0 0
1 3 0 00001007 11223344 00000000 00000000 0 0 00000000 8 44112233 0 00000000 0 0
1 1 0 0000100c 11223344 00000000 00000000 0 0 00000000 3 11223344 0 00000000 0 0
1 1 0 00001011 11223344 00000000 00000000 0 0 00000000 6 22334411 0 00000000 0 0
1 0 0 00002001 11223344 00000000 00000000 0 0 00000000 e 22334411 1 22334411 0 0
1 0 0 00002006 11223344 00000000 00000000 0 0 00000000 c 33441122 3 33441122 0 0
1 0 0 0000200b 11223344 00000000 00000000 0 0 00000000 8 44112233 7 44112233 0 0
1 1 0 0000200f 11223344 00000000 00000000 0 0 00000000 8 44112233 1 44112233 0 0
0 0 0 00003000 00000000 a1b2c3d4 15263748 0 0 a1b2c3d4 f 00000000 0 00000000 0 0
0 1 1 00003004 00000000 a1b2c3d4 15263748 0 0 ffffc3d4 3 00000000 0 00000000 0 0
0 1 0 00003006 00000000 a1b2c3d4 15263748 0 0 0000a1b2 c 00000000 0 00000000 0 0
0 1 1 00003009 00000000 a1b2c3d4 15263748 0 0 ffffb2c3 6 00000000 0 00000000 0 0
0 2 1 0000300c 00000000 a1b2c3d4 15263748 0 0 ffffffd4 1 00000000 0 00000000 0 0
0 2 0 0000300d 00000000 a1b2c3d4 15263748 0 0 000000c3 2 00000000 0 00000000 0 0
0 3 1 0000300e 00000000 a1b2c3d4 15263748 0 0 ffffffb2 4 00000000 0 00000000 0 0
0 2 1 0000300f 00000000 7f6e5d4c 15263748 0 0 0000007f 8 00000000 0 00000000 0 0
0 0 0 00004001 00000000 a1b2c3d4 15263748 0 0 48a1b2c3 e 00000000 1 00000000 0 0
0 0 0 00004006 00000000 a1b2c3d4 15263748 0 0 3748a1b2 c 00000000 3 00000000 0 0
0 0 0 0000400b 00000000 a1b2c3d4 15263748 0 0 263748a1 8 00000000 7 00000000 0 0
0 1 1 0000400f 00000000 a1b2c3d4 15263798 0 0 ffff98a1 8 00000000 1 00000000 0 0
0 1 0 0000400f 00000000 a1b2c3d4 15263748 0 0 000048a1 8 00000000 1 00000000 0 0
0 0 0 00005002 00000000 a1b2c3d4 15263748 1 0 00000000 c 00000000 3 00000000 1 0
0 0 0 00005005 00000000 a1b2c3d4 15263748 0 1 00000000 e 00000000 1 00000000 1 0
1 0 0 0000500b 11223344 00000000 00000000 1 0 00000000 8 44112233 7 44112233 0 1
1 0 0 00005010 11223344 00000000 00000000 1 0 00000000 f 11223344 0 00000000 0 1
0 2 0 00005014 00000000 a1b2c3d4 15263748 1 0 00000000 1 00000000 0 00000000 1 0
1 1 0 0000501f 11223344 00000000 00000000 0 1 00000000 8 44112233 1 44112233 0 1
